//--- dmem_access.f
+incdir+include
verilog/dmem_pkg.sv
verilog/dmem_access_chk.sv
verilog/dmem_wbuf.sv
verilog/dmem_biu_ctrl.sv
verilog/dmem_access_top.sv
verif/dmem_tb.sv

//--- include/dmem_config.svh
// data access path configuration

`ifndef DMEM_CONFIG_SVH
`define DMEM_CONFIG_SVH

// address and data width
`define DMEM_XLEN 32

// write buffer entries, power of two
`define DMEM_WBUF_DEPTH 4

// everything below this address is cacheable
`define DMEM_CACHEABLE_LIMIT 32'h8000_0000

////////////////////////////////////////
// bus protection bits
////////////////////////////////////////
`define DMEM_PROT_W     3
`define DMEM_PROT_DATA  0  // data access, never instruction
`define DMEM_PROT_PRIV  1  // privileged mode
`define DMEM_PROT_CACHE 2  // cacheable region

`endif

//--- run_sim.sh
#!/bin/sh
# build and run the data access testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module dmem_tb -f dmem_access.f

out=$(./obj_dir/Vdmem_tb)
echo "$out"

if echo "$out" | grep -q "Simulation finished: PASS"; then
  exit 0
else
  exit 1
fi

//--- verif/dmem_tb.sv
// data access path testbench

`timescale 1ns/1ps
`include "dmem_config.svh"

module dmem_tb
  import dmem_pkg::*;
();

  localparam int              N_REQ    = 32;
  localparam logic [31:0]     ERR_BASE = 32'hF000_0000;

  logic                       clk_i;
  logic                       rst_i;
  logic                       mem_req_i;
  logic [`DMEM_XLEN-1:0]      mem_adr_i;
  biu_size_e                  mem_size_i;
  logic                       mem_we_i;
  logic [`DMEM_XLEN-1:0]      mem_d_i;
  prv_e                       st_prv_i;
  logic                       mem_ack_o;
  logic [`DMEM_XLEN-1:0]      mem_q_o;
  logic                       mem_err_o;
  logic                       mem_misaligned_o;
  logic                       biu_stb_o;
  logic                       biu_stb_ack_i;
  logic [`DMEM_XLEN-1:0]      biu_adri_o;
  biu_size_e                  biu_size_o;
  logic                       biu_we_o;
  logic [`DMEM_XLEN-1:0]      biu_d_o;
  logic [`DMEM_PROT_W-1:0]    biu_prot_o;
  logic [`DMEM_XLEN-1:0]      biu_q_i;
  logic                       biu_ack_i;
  logic                       biu_err_i;

  logic [7:0]  shadow [logic [31:0]];   // memory as the cpu sees it, program order
  logic [7:0]  bus_mem [logic [31:0]];  // responder storage
  logic        exp_mis [$];
  logic        exp_rd [$];
  logic        exp_err [$];
  logic [31:0] exp_q [$];
  logic [69:0] exp_xfer [$];            // adr, size, we, d, prot
  logic [31:0] bus_log [$];
  int          err_cnt = 0;
  int          n_req = 0;
  int          n_xfer = 0;
  int          n_ack = 0;
  int          wr_stall = 0;
  logic        slow_stb = 1'b0;

  dmem_access_top u_dut (.*);

  initial
  begin : clock
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////
  function automatic logic [7:0] fill_byte(input logic [31:0] a);
    fill_byte = a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'ha5;  // never written
  endfunction

  function automatic logic [3:0] lane_mask(input logic [31:0] adr, input biu_size_e size);
    case (size)
      SIZE_BYTE:  lane_mask = 4'b0001 << adr[1:0];
      SIZE_HWORD: lane_mask = 4'b0011 << {adr[1], 1'b0};
      default:    lane_mask = 4'b1111;
    endcase
  endfunction

  // returns error flag, prot and the aligned word
  function automatic logic [35:0] ref_model(input logic [31:0] adr, input prv_e prv);
    logic [31:0] word;
    logic [31:0] a;
    logic [2:0]  prot;
    for (int i = 0; i < 4; i++)
    begin
      a = {adr[31:2], 2'(i)};
      word[8*i +: 8] = shadow.exists(a) ? shadow[a] : fill_byte(a);
    end
    prot                   = '0;
    prot[`DMEM_PROT_DATA]  = 1'b1;
    prot[`DMEM_PROT_PRIV]  = (prv != PRV_U);
    prot[`DMEM_PROT_CACHE] = (adr < `DMEM_CACHEABLE_LIMIT);
    ref_model = {adr >= ERR_BASE, prot, word};
  endfunction

  task automatic shadow_write(input logic [31:0] adr, input biu_size_e size,
                              input logic [31:0] d);
    logic [3:0] be;
    be = lane_mask(adr, size);
    for (int i = 0; i < 4; i++)
      if (be[i] && adr < ERR_BASE)
        shadow[{adr[31:2], 2'(i)}] = d[8*i +: 8];
  endtask

  task automatic report_error(input string name, input logic [31:0] got, input logic [31:0] exp);
    err_cnt++;
    $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
  endtask

  // one cpu request, held until mem_ack_o
  task automatic cpu_access(input logic [31:0] adr, input biu_size_e size, input logic we,
                            input logic [31:0] d, input prv_e prv);
    logic        mis;
    logic [35:0] r;
    mis = (size == SIZE_HWORD && adr[0]) || (size == SIZE_WORD && adr[1:0] != 2'b00);
    r   = ref_model(adr, prv);
    exp_mis.push_back(mis);
    exp_rd.push_back(!we && !mis);
    exp_err.push_back(!we && !mis && r[35]);  // posted write errors never reach the cpu
    exp_q.push_back(r[31:0]);
    if (!mis)
    begin
      exp_xfer.push_back({adr, size, we, (we ? d : 32'h0), r[34:32]});
      n_xfer++;
      if (we)
        shadow_write(adr, size, d);
    end
    mem_req_i  = 1'b1;
    mem_adr_i  = adr;
    mem_size_i = size;
    mem_we_i   = we;
    mem_d_i    = d;
    st_prv_i   = prv;
    do
      @(posedge clk_i);
    while (!mem_ack_o);
    #1 mem_req_i = 1'b0;
    n_req++;
  endtask

  ////////////////////////////////////////
  // bus responder
  ////////////////////////////////////////
  initial
  begin : biu_model
    logic [31:0] adr;
    logic [31:0] d;
    logic [31:0] a;
    logic [3:0]  be;
    logic        we;
    int          dly;
    biu_stb_ack_i = 1'b0;
    biu_ack_i     = 1'b0;
    biu_err_i     = 1'b0;
    biu_q_i       = '0;
    forever
    begin
      @(posedge clk_i);
      if (!rst_i && biu_stb_o)
      begin
        adr = biu_adri_o;
        we  = biu_we_o;
        d   = biu_d_o;
        be  = lane_mask(biu_adri_o, biu_size_o);
        dly = slow_stb ? 3 : int'($urandom_range(3, 0));
        #1;
        repeat (dly)
        begin
          @(posedge clk_i);
          #1;
        end
        biu_stb_ack_i = 1'b1;
        @(posedge clk_i);
        bus_log.push_back(adr);  // accepted on this edge
        #1 biu_stb_ack_i = 1'b0;
        dly = int'($urandom_range(3, 0));
        repeat (dly)
        begin
          @(posedge clk_i);
          #1;
        end
        if (adr >= ERR_BASE)
        begin
          biu_err_i = 1'b1;
          biu_q_i   = '0;
        end
        else
        begin
          biu_ack_i = 1'b1;
          for (int i = 0; i < 4; i++)
          begin
            a = {adr[31:2], 2'(i)};
            if (we && be[i])
              bus_mem[a] = d[8*i +: 8];
            biu_q_i[8*i +: 8] = bus_mem.exists(a) ? bus_mem[a] : fill_byte(a);
          end
        end
        @(posedge clk_i);
        #1;
        biu_ack_i = 1'b0;
        biu_err_i = 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // compare
  ////////////////////////////////////////
  initial
  begin : compare
    logic [69:0] x;
    logic        m;
    logic        rd;
    logic        e;
    logic [31:0] q;
    forever
    begin
      @(posedge clk_i);
      if (!rst_i && mem_req_i && mem_we_i && !mem_ack_o)
        wr_stall++;  // write held back by a full buffer
      if (!rst_i && mem_ack_o)
      begin
        n_ack++;
        if (exp_mis.size() == 0)
        begin
          err_cnt++;
          $display("mem_ack_o came at %0t with no request waiting for it", $time);
        end
        else
        begin
          m  = exp_mis.pop_front();
          rd = exp_rd.pop_front();
          e  = exp_err.pop_front();
          q  = exp_q.pop_front();
          if (mem_misaligned_o !== m)
            report_error("mem_misaligned_o", mem_misaligned_o, m);
          if (mem_err_o !== e)
            report_error("mem_err_o", mem_err_o, e);
          if (rd && !e && mem_q_o !== q)
            report_error("mem_q_o", mem_q_o, q);
        end
      end
      if (!rst_i && biu_stb_o && biu_stb_ack_i)
      begin
        if (exp_xfer.size() == 0)
        begin
          err_cnt++;
          $display("bus transfer to %h at %0t that no request asked for", biu_adri_o, $time);
        end
        else
        begin
          x = exp_xfer.pop_front();
          if (biu_adri_o !== x[69:38])
            report_error("biu_adri_o", biu_adri_o, x[69:38]);
          if (biu_size_o !== x[37:36])
            report_error("biu_size_o", biu_size_o, x[37:36]);
          if (biu_we_o !== x[35])
            report_error("biu_we_o", biu_we_o, x[35]);
          if (x[35] && biu_d_o !== x[34:3])
            report_error("biu_d_o", biu_d_o, x[34:3]);
          if (biu_prot_o !== x[2:0])
            report_error("biu_prot_o", biu_prot_o, x[2:0]);
        end
      end
    end
  end

  initial
  begin : watchdog
    #(N_REQ * 20 * 8 + 8 * 8);
    $display("timeout: the run did not end within the time allowed for %0d requests", N_REQ);
    $display("Simulation finished: FAIL");
    $finish;
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////
  initial
  begin : stimulus
    prv_e prv;
    int   stall_mark;
    void'($urandom(32'h538f));
    rst_i      = 1'b1;
    mem_req_i  = 1'b0;
    mem_adr_i  = '0;
    mem_size_i = SIZE_WORD;
    mem_we_i   = 1'b0;
    mem_d_i    = '0;
    st_prv_i   = PRV_M;
    repeat (8) @(posedge clk_i);
    #1 rst_i = 1'b0;
    @(posedge clk_i);
    if (biu_stb_o !== 1'b0)
      report_error("biu_stb_o", biu_stb_o, 1'b0);
    if (mem_ack_o !== 1'b0)
      report_error("mem_ack_o", mem_ack_o, 1'b0);
    #1;

    // misaligned, acked at once
    cpu_access(32'h0000_0101, SIZE_HWORD, 1'b1, 32'h1234_5678, PRV_U);
    cpu_access(32'h0000_0102, SIZE_WORD, 1'b0, 32'h0, PRV_M);

    // every size, merged in one word
    cpu_access(32'h0000_0200, SIZE_WORD, 1'b1, $urandom, PRV_M);
    cpu_access(32'h0000_0200, SIZE_WORD, 1'b0, 32'h0, PRV_M);
    cpu_access(32'h0000_0201, SIZE_BYTE, 1'b1, $urandom, PRV_S);
    cpu_access(32'h0000_0203, SIZE_BYTE, 1'b1, $urandom, PRV_U);
    cpu_access(32'h0000_0203, SIZE_BYTE, 1'b0, 32'h0, PRV_U);
    cpu_access(32'h0000_0202, SIZE_HWORD, 1'b1, $urandom, PRV_S);
    cpu_access(32'h0000_0202, SIZE_HWORD, 1'b0, 32'h0, PRV_S);
    cpu_access(32'h0000_0300, SIZE_WORD, 1'b0, 32'h0, PRV_M);  // fill pattern

    // prot on both sides of the cacheable limit
    for (int p = 0; p < 3; p++)
    begin
      prv = (p == 0) ? PRV_U : (p == 1) ? PRV_S : PRV_M;
      cpu_access(32'h7fff_fff0, SIZE_WORD, 1'b1, $urandom, prv);
      cpu_access(32'h7fff_fff0, SIZE_WORD, 1'b0, 32'h0, prv);
      cpu_access(`DMEM_CACHEABLE_LIMIT, SIZE_WORD, 1'b1, $urandom, prv);
      cpu_access(`DMEM_CACHEABLE_LIMIT, SIZE_WORD, 1'b0, 32'h0, prv);
    end

    // slow stb ack, burst fills the buffer
    stall_mark = wr_stall;
    slow_stb   = 1'b1;
    for (int i = 0; i < 6; i++)
      cpu_access(32'h0000_0400 + 32'(4 * i), SIZE_WORD, 1'b1, $urandom, PRV_M);
    if (wr_stall == stall_mark)
    begin
      err_cnt++;
      $display("the write burst never waited on a full buffer");
    end
    cpu_access(32'h0000_0414, SIZE_WORD, 1'b0, 32'h0, PRV_M);
    slow_stb = 1'b0;

    // error region
    cpu_access(32'hf000_0010, SIZE_WORD, 1'b0, 32'h0, PRV_M);
    cpu_access(32'hf000_0020, SIZE_WORD, 1'b1, $urandom, PRV_M);
    cpu_access(32'h0000_0200, SIZE_WORD, 1'b0, 32'h0, PRV_M);

    while (exp_xfer.size() != 0)
      @(posedge clk_i);  // last posted write still on the bus
    repeat (4) @(posedge clk_i);
    if (exp_mis.size() != 0)
    begin
      err_cnt++;
      $display("%0d requests never got mem_ack_o", exp_mis.size());
    end
    if (bus_log.size() != n_xfer)
    begin
      err_cnt++;
      $display("the bus saw %0d transfers instead of %0d", bus_log.size(), n_xfer);
    end
    $display("summary: %0d errors, %0d requests, %0d acks, %0d transfers",
             err_cnt, n_req, n_ack, bus_log.size());
    if (err_cnt == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- verilog/dmem_access_chk.sv
// data request check and posting

`timescale 1ns/1ps
`include "dmem_config.svh"

module dmem_access_chk
  import dmem_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_i,

  input  logic                       mem_req_i,
  input  logic [`DMEM_XLEN-1:0]      mem_adr_i,
  input  biu_size_e                  mem_size_i,
  input  logic                       mem_we_i,
  input  logic [`DMEM_XLEN-1:0]      mem_d_i,
  input  prv_e                       st_prv_i,
  output logic                       mem_ack_o,
  output logic [`DMEM_XLEN-1:0]      mem_q_o,
  output logic                       mem_err_o,
  output logic                       mem_misaligned_o,

  input  logic                       wbuf_full_i,
  output logic                       wbuf_push_o,
  output logic [`DMEM_XLEN-1:0]      wbuf_adr_o,
  output biu_size_e                  wbuf_size_o,
  output logic                       wbuf_we_o,
  output logic [`DMEM_XLEN-1:0]      wbuf_d_o,
  output logic [`DMEM_PROT_W-1:0]    wbuf_prot_o,

  input  logic                       rd_done_i,
  input  logic [`DMEM_XLEN-1:0]      rd_q_i,
  input  logic                       rd_err_i
);

  logic                  misaligned;
  logic                  req_seen;    // request not masked by a pending read
  logic                  rd_pend;
  logic                  resp_ack;
  logic                  resp_err;
  logic [`DMEM_XLEN-1:0] resp_q;

  ////////////////////////////////////////
  // alignment and prot
  ////////////////////////////////////////
  assign misaligned = ((mem_size_i == SIZE_HWORD) & mem_adr_i[0]) |
                      ((mem_size_i == SIZE_WORD) & (mem_adr_i[1:0] != 2'b00));

  always_comb
  begin
    wbuf_prot_o                   = '0;
    wbuf_prot_o[`DMEM_PROT_DATA]  = 1'b1;
    wbuf_prot_o[`DMEM_PROT_PRIV]  = (st_prv_i != PRV_U);
    wbuf_prot_o[`DMEM_PROT_CACHE] = (mem_adr_i < `DMEM_CACHEABLE_LIMIT);
  end

  ////////////////////////////////////////
  // request handling
  ////////////////////////////////////////
  assign req_seen         = mem_req_i & ~rd_pend;  // the held read is ignored
  assign mem_misaligned_o = req_seen & misaligned;
  assign wbuf_push_o      = req_seen & ~misaligned & ~wbuf_full_i;

  assign wbuf_adr_o  = mem_adr_i;
  assign wbuf_size_o = mem_size_i;
  assign wbuf_we_o   = mem_we_i;
  assign wbuf_d_o    = mem_d_i;

  // misaligned and posted writes ack at once, reads ack from the response register
  assign mem_ack_o = mem_misaligned_o | (wbuf_push_o & mem_we_i) | resp_ack;
  assign mem_q_o   = resp_q;
  assign mem_err_o = resp_err;

  // pending read stays set through the ack cycle so the held request is not pushed twice
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      rd_pend  <= 1'b0;
      resp_ack <= 1'b0;
      resp_err <= 1'b0;
    end
    else
    begin
      if (wbuf_push_o & ~mem_we_i)
        rd_pend <= 1'b1;
      else if (resp_ack)
        rd_pend <= 1'b0;
      resp_ack <= rd_done_i;
      resp_err <= rd_done_i & rd_err_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rd_done_i)
      resp_q <= rd_q_i;  // read data from the bus
  end

  a_rd_done_pending: assert property (@(posedge clk_i) disable iff (rst_i)
    rd_done_i |-> rd_pend);

  a_req_held: assert property (@(posedge clk_i) disable iff (rst_i)
    (mem_req_i && !mem_ack_o) |=> (mem_req_i && $stable(mem_adr_i)));

endmodule

//--- verilog/dmem_access_top.sv
// uncached data access top level

`timescale 1ns/1ps
`include "dmem_config.svh"

module dmem_access_top
  import dmem_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_i,

  // cpu side
  input  logic                       mem_req_i,
  input  logic [`DMEM_XLEN-1:0]      mem_adr_i,
  input  biu_size_e                  mem_size_i,
  input  logic                       mem_we_i,
  input  logic [`DMEM_XLEN-1:0]      mem_d_i,
  input  prv_e                       st_prv_i,
  output logic                       mem_ack_o,
  output logic [`DMEM_XLEN-1:0]      mem_q_o,
  output logic                       mem_err_o,
  output logic                       mem_misaligned_o,

  // bus side
  output logic                       biu_stb_o,
  input  logic                       biu_stb_ack_i,
  output logic [`DMEM_XLEN-1:0]      biu_adri_o,
  output biu_size_e                  biu_size_o,
  output logic                       biu_we_o,
  output logic [`DMEM_XLEN-1:0]      biu_d_o,
  output logic [`DMEM_PROT_W-1:0]    biu_prot_o,
  input  logic [`DMEM_XLEN-1:0]      biu_q_i,
  input  logic                       biu_ack_i,
  input  logic                       biu_err_i
);

  // producer to buffer
  logic                    wbuf_push;
  logic [`DMEM_XLEN-1:0]   wbuf_adr;
  biu_size_e               wbuf_size;
  logic                    wbuf_we;
  logic [`DMEM_XLEN-1:0]   wbuf_d;
  logic [`DMEM_PROT_W-1:0] wbuf_prot;
  logic                    wbuf_full;

  // buffer head to consumer
  logic                    wbuf_empty;
  logic [`DMEM_XLEN-1:0]   wbuf_adr_q;
  biu_size_e               wbuf_size_q;
  logic                    wbuf_we_q;
  logic [`DMEM_XLEN-1:0]   wbuf_d_q;
  logic [`DMEM_PROT_W-1:0] wbuf_prot_q;
  logic                    wbuf_pop;

  // read completion back to producer
  logic                    rd_done;
  logic [`DMEM_XLEN-1:0]   rd_q;
  logic                    rd_err;

  ////////////////////////////////////////
  // producer
  ////////////////////////////////////////
  dmem_access_chk u_chk (
    .clk_i            ( clk_i            ),
    .rst_i            ( rst_i            ),
    .mem_req_i        ( mem_req_i        ),
    .mem_adr_i        ( mem_adr_i        ),
    .mem_size_i       ( mem_size_i       ),
    .mem_we_i         ( mem_we_i         ),
    .mem_d_i          ( mem_d_i          ),
    .st_prv_i         ( st_prv_i         ),
    .mem_ack_o        ( mem_ack_o        ),
    .mem_q_o          ( mem_q_o          ),
    .mem_err_o        ( mem_err_o        ),
    .mem_misaligned_o ( mem_misaligned_o ),
    .wbuf_full_i      ( wbuf_full        ),
    .wbuf_push_o      ( wbuf_push        ),
    .wbuf_adr_o       ( wbuf_adr         ),
    .wbuf_size_o      ( wbuf_size        ),
    .wbuf_we_o        ( wbuf_we          ),
    .wbuf_d_o         ( wbuf_d           ),
    .wbuf_prot_o      ( wbuf_prot        ),
    .rd_done_i        ( rd_done          ),
    .rd_q_i           ( rd_q             ),
    .rd_err_i         ( rd_err           )
  );

  ////////////////////////////////////////
  // write buffer
  ////////////////////////////////////////
  dmem_wbuf #(
    .DEPTH ( `DMEM_WBUF_DEPTH )
  ) u_wbuf (
    .clk_i   ( clk_i       ),
    .rst_i   ( rst_i       ),
    .push_i  ( wbuf_push   ),
    .adr_i   ( wbuf_adr    ),
    .size_i  ( wbuf_size   ),
    .we_i    ( wbuf_we     ),
    .d_i     ( wbuf_d      ),
    .prot_i  ( wbuf_prot   ),
    .pop_i   ( wbuf_pop    ),
    .full_o  ( wbuf_full   ),
    .empty_o ( wbuf_empty  ),
    .adr_o   ( wbuf_adr_q  ),
    .size_o  ( wbuf_size_q ),
    .we_o    ( wbuf_we_q   ),
    .d_o     ( wbuf_d_q    ),
    .prot_o  ( wbuf_prot_q )
  );

  ////////////////////////////////////////
  // consumer
  ////////////////////////////////////////
  dmem_biu_ctrl u_biu (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .wbuf_empty_i  ( wbuf_empty    ),
    .wbuf_adr_i    ( wbuf_adr_q    ),
    .wbuf_size_i   ( wbuf_size_q   ),
    .wbuf_we_i     ( wbuf_we_q     ),
    .wbuf_d_i      ( wbuf_d_q      ),
    .wbuf_prot_i   ( wbuf_prot_q   ),
    .wbuf_pop_o    ( wbuf_pop      ),
    .biu_stb_o     ( biu_stb_o     ),
    .biu_stb_ack_i ( biu_stb_ack_i ),
    .biu_adri_o    ( biu_adri_o    ),
    .biu_size_o    ( biu_size_o    ),
    .biu_we_o      ( biu_we_o      ),
    .biu_d_o       ( biu_d_o       ),
    .biu_prot_o    ( biu_prot_o    ),
    .biu_q_i       ( biu_q_i       ),
    .biu_ack_i     ( biu_ack_i     ),
    .biu_err_i     ( biu_err_i     ),
    .rd_done_o     ( rd_done       ),
    .rd_q_o        ( rd_q          ),
    .rd_err_o      ( rd_err        )
  );

endmodule

//--- verilog/dmem_biu_ctrl.sv
// uncached bus transfer control

`timescale 1ns/1ps
`include "dmem_config.svh"

module dmem_biu_ctrl
  import dmem_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_i,

  input  logic                       wbuf_empty_i,
  input  logic [`DMEM_XLEN-1:0]      wbuf_adr_i,
  input  biu_size_e                  wbuf_size_i,
  input  logic                       wbuf_we_i,
  input  logic [`DMEM_XLEN-1:0]      wbuf_d_i,
  input  logic [`DMEM_PROT_W-1:0]    wbuf_prot_i,
  output logic                       wbuf_pop_o,

  output logic                       biu_stb_o,
  input  logic                       biu_stb_ack_i,
  output logic [`DMEM_XLEN-1:0]      biu_adri_o,
  output biu_size_e                  biu_size_o,
  output logic                       biu_we_o,
  output logic [`DMEM_XLEN-1:0]      biu_d_o,
  output logic [`DMEM_PROT_W-1:0]    biu_prot_o,
  input  logic [`DMEM_XLEN-1:0]      biu_q_i,
  input  logic                       biu_ack_i,
  input  logic                       biu_err_i,

  output logic                       rd_done_o,
  output logic [`DMEM_XLEN-1:0]      rd_q_o,
  output logic                       rd_err_o
);

  biu_state_e state;
  biu_state_e state_nxt;
  logic       xfer_end;  // data phase done, ack or error

  ////////////////////////////////////////
  // transfer state machine
  ////////////////////////////////////////
  assign xfer_end = (state == ST_WAIT) & (biu_ack_i | biu_err_i);

  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_IDLE: if (!wbuf_empty_i)  state_nxt = ST_STB;
      ST_STB:  if (biu_stb_ack_i)  state_nxt = ST_WAIT;
      ST_WAIT: if (xfer_end)       state_nxt = ST_IDLE;
      default:                     state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      state <= ST_IDLE;
    else
      state <= state_nxt;
  end

  // head entry stays put until the pop, so the bus fields hold steady
  assign biu_stb_o  = (state == ST_STB);
  assign biu_adri_o = wbuf_adr_i;
  assign biu_size_o = wbuf_size_i;
  assign biu_we_o   = wbuf_we_i;
  assign biu_d_o    = wbuf_d_i;
  assign biu_prot_o = wbuf_prot_i;

  ////////////////////////////////////////
  // completion
  ////////////////////////////////////////
  assign wbuf_pop_o = xfer_end;
  assign rd_done_o  = xfer_end & ~wbuf_we_i;  // write errors are dropped
  assign rd_q_o     = biu_q_i;
  assign rd_err_o   = biu_err_i;

  a_stb_adr_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (biu_stb_o && !biu_stb_ack_i) |=> (biu_stb_o && $stable(biu_adri_o)));

endmodule

//--- verilog/dmem_pkg.sv
// data access path types

package dmem_pkg;

  // transfer size, matches the BIU encoding
  typedef enum logic [1:0] {
    SIZE_BYTE  = 2'b00,
    SIZE_HWORD = 2'b01,
    SIZE_WORD  = 2'b10
  } biu_size_e;

  // privilege levels as encoded by the core
  typedef enum logic [1:0] {
    PRV_U = 2'b00,
    PRV_S = 2'b01,
    PRV_M = 2'b11
  } prv_e;

  // consumer bus transfer states
  typedef enum logic [1:0] {
    ST_IDLE = 2'b00,  // waiting for a buffer entry
    ST_STB  = 2'b01,  // strobe out, waiting for stb ack
    ST_WAIT = 2'b10   // address taken, waiting for data ack
  } biu_state_e;

endpackage

//--- verilog/dmem_wbuf.sv
// data write buffer fifo

`timescale 1ns/1ps
`include "dmem_config.svh"

module dmem_wbuf
  import dmem_pkg::*;
#(
  parameter int DEPTH = `DMEM_WBUF_DEPTH
)
(
  input  logic                       clk_i,
  input  logic                       rst_i,

  input  logic                       push_i,
  input  logic [`DMEM_XLEN-1:0]      adr_i,
  input  biu_size_e                  size_i,
  input  logic                       we_i,
  input  logic [`DMEM_XLEN-1:0]      d_i,
  input  logic [`DMEM_PROT_W-1:0]    prot_i,

  input  logic                       pop_i,
  output logic                       full_o,
  output logic                       empty_o,
  output logic [`DMEM_XLEN-1:0]      adr_o,
  output biu_size_e                  size_o,
  output logic                       we_o,
  output logic [`DMEM_XLEN-1:0]      d_o,
  output logic [`DMEM_PROT_W-1:0]    prot_o
);

  localparam int            AW      = $clog2(DEPTH);
  localparam logic [AW:0]   CNT_MAX = (AW+1)'(DEPTH);

  logic [`DMEM_XLEN-1:0]   adr_mem  [DEPTH];
  biu_size_e               size_mem [DEPTH];
  logic                    we_mem   [DEPTH];
  logic [`DMEM_XLEN-1:0]   d_mem    [DEPTH];
  logic [`DMEM_PROT_W-1:0] prot_mem [DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   cnt;    // one bit wider to tell full from empty

  ////////////////////////////////////////
  // pointers and fill level
  ////////////////////////////////////////
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two
      if (pop_i)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push_i, pop_i})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: cnt <= cnt;      // none, or push and pop together
      endcase
    end
  end

  // entry storage
  always_ff @(posedge clk_i)
  begin
    if (push_i)
    begin
      adr_mem[wr_ptr]  <= adr_i;
      size_mem[wr_ptr] <= size_i;
      we_mem[wr_ptr]   <= we_i;
      d_mem[wr_ptr]    <= d_i;
      prot_mem[wr_ptr] <= prot_i;
    end
  end

  assign full_o  = (cnt == CNT_MAX);
  assign empty_o = (cnt == '0);

  // head entry
  assign adr_o  = adr_mem[rd_ptr];
  assign size_o = size_mem[rd_ptr];
  assign we_o   = we_mem[rd_ptr];
  assign d_o    = d_mem[rd_ptr];
  assign prot_o = prot_mem[rd_ptr];

  a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
    full_o |-> !push_i);

  a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
    empty_o |-> !pop_i);

endmodule
